// ==== data_ram.sv ====
// Word-addressed RAM with byte-enabled writes and a registered one-cycle read.
`timescale 1ns/10ps

module data_ram #(
  parameter int unsigned MEM_WORDS = 256 // power of two, so low address bits index it.
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  pkg_mem::mem_req_t i_req,
  output pkg_mem::mem_rsp_t o_rsp
);
  import pkg_mem::*;

  localparam int unsigned IDX_W = $clog2(MEM_WORDS); // bits of the word index.

  logic [XLEN-1:0]  mem [MEM_WORDS]; // storage array.
  logic [IDX_W-1:0] idx;             // word address folded onto the array.
  logic [XLEN-1:0]  rdata_q;         // registered read word.
  logic             valid_q;         // a read was issued last cycle.

  assign idx = i_req.addr[IDX_W-1:0]; // higher address bits alias.

  // ----------------------------------------------------------
  // array access
  // ----------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_req.we) begin
      for (int b = 0; b < BE_W; b++) begin
        if (i_req.be[b]) begin
          mem[idx][8*b +: 8] <= i_req.wdata[8*b +: 8]; // only enabled lanes change.
        end
      end
    end
    if (i_req.rd) begin
      rdata_q <= mem[idx];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_req.rd;
    end
  end

  assign o_rsp.valid = valid_q;
  assign o_rsp.rdata = rdata_q;

endmodule

// ==== fetch_port.sv ====
// Fetch requester that holds one word read until the arbiter grants it, then returns the word.
`timescale 1ns/10ps

module fetch_port (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_stb,
  input  logic [pkg_mem::XLEN-1:0] i_addr,
  input  logic                     i_gnt,
  input  pkg_mem::mem_rsp_t        i_rsp,
  output pkg_mem::mem_req_t        o_bus,
  output logic                     o_valid,
  output logic [pkg_mem::XLEN-1:0] o_data
);
  import pkg_mem::*;

  logic               pend;   // a read is waiting for the RAM.
  logic [WADDR_W-1:0] addr_q; // word address of the waiting read.
  logic               own;    // the next response is this port's.

  // the request goes up in the strobe cycle itself, so a free RAM grants at once.
  always_comb begin
    o_bus      = '0;
    o_bus.rd   = pend || i_stb;
    o_bus.addr = pend ? addr_q : i_addr[XLEN-1:2];
    o_bus.be   = '1; // whole word, ignored by reads.
  end

  always_ff @(posedge i_clk) begin
    if (i_stb) begin
      addr_q <= i_addr[XLEN-1:2];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pend <= 1'b0;
      own  <= 1'b0;
    end else begin
      pend <= o_bus.rd && !i_gnt; // keep asking until granted.
      own  <= i_gnt;              // granted read answers next cycle.
    end
  end

  assign o_valid = own && i_rsp.valid;
  assign o_data  = i_rsp.rdata;

  // only one fetch may be outstanding.
  a_one_pending : assert property (@(posedge i_clk) disable iff (i_rst)
    i_stb |-> !pend)
    else $error("fetch_port: new fetch strobed while one is pending.");

endmodule

// ==== load_store.sv ====
// Load/store unit: address generation, store lane placement, load extension and alignment checks.
`timescale 1ns/10ps

module load_store (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_stb,
  input  pkg_defines::lsu_req_t   i_req,
  input  pkg_mem::mem_rsp_t       i_rsp,
  output pkg_mem::mem_req_t       o_bus,
  output logic                    o_ld_valid,
  output logic [pkg_mem::XLEN-1:0] o_ld_result,
  output logic                    o_misaligned
);
  import pkg_defines::*;
  import pkg_mem::*;

  logic [XLEN-1:0] addr;      // effective byte address.
  logic            is_load;   // the kind reads memory.
  logic            is_store;  // the kind writes memory.
  logic            bad_align; // address offset does not suit the access size.
  logic            ld_pend;   // the next response belongs to this unit.
  logic            mis_q;     // misaligned flag, one cycle late.
  instr_name_e     ld_kind;   // kind of the load in flight.
  logic [1:0]      ld_lane;   // byte offset of the load in flight.
  logic [XLEN-1:0] ld_word;   // response shifted so the addressed byte sits at bit 0.

  // ----------------------------------------------------------
  // request side
  // ----------------------------------------------------------
  assign addr = i_req.base + i_req.imm; // base plus immediate, wraps like the ALU.

  always_comb begin
    is_load   = 1'b0;
    is_store  = 1'b0;
    bad_align = 1'b0;
    case (i_req.instr)
      LB, LBU: is_load = 1'b1; // bytes are never misaligned.
      LH, LHU: begin
        is_load   = 1'b1;
        bad_align = addr[0]; // halfwords need an even address.
      end
      LW: begin
        is_load   = 1'b1;
        bad_align = |addr[1:0]; // words need a multiple of four.
      end
      SB: is_store = 1'b1;
      SH: begin
        is_store  = 1'b1;
        bad_align = addr[0];
      end
      SW: begin
        is_store  = 1'b1;
        bad_align = |addr[1:0];
      end
      default: ; // NONE drives nothing onto the bus.
    endcase
  end

  // a misaligned access raises no strobe, so memory is left untouched.
  always_comb begin
    o_bus       = '0;
    o_bus.rd    = i_stb && is_load && !bad_align;
    o_bus.we    = i_stb && is_store && !bad_align;
    o_bus.addr  = addr[XLEN-1:2];                               // word part of the address.
    o_bus.wdata = i_req.store_data << {addr[1:0], 3'b000};      // move data up to its lane.
    case (i_req.instr)
      SB:      o_bus.be = 4'b0001 << addr[1:0]; // one lane.
      SH:      o_bus.be = 4'b0011 << addr[1:0]; // two lanes, offset is 0 or 2.
      default: o_bus.be = 4'b1111;              // whole word.
    endcase
  end

  // ----------------------------------------------------------
  // response side
  // ----------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ld_pend <= 1'b0;
      mis_q   <= 1'b0;
    end else begin
      ld_pend <= o_bus.rd;            // the arbiter never stalls this unit.
      mis_q   <= i_stb && bad_align;  // only loads and stores can set bad_align.
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_bus.rd) begin
      ld_kind <= i_req.instr;
      ld_lane <= addr[1:0];
    end
  end

  assign ld_word = i_rsp.rdata >> {ld_lane, 3'b000}; // aligned loads keep lane in range.

  always_comb begin
    case (ld_kind)
      LB:      o_ld_result = {{(XLEN-8){ld_word[7]}}, ld_word[7:0]};
      LBU:     o_ld_result = {{(XLEN-8){1'b0}}, ld_word[7:0]};
      LH:      o_ld_result = {{(XLEN-16){ld_word[15]}}, ld_word[15:0]};
      LHU:     o_ld_result = {{(XLEN-16){1'b0}}, ld_word[15:0]};
      default: o_ld_result = ld_word; // LW, offset is zero.
    endcase
  end

  assign o_ld_valid   = ld_pend && i_rsp.valid;
  assign o_misaligned = mis_q;

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  a_rd_we_excl : assert property (@(posedge i_clk) disable iff (i_rst)
    !(o_bus.rd && o_bus.we))
    else $error("load_store: read and write strobes raised together.");

  // a load always wins arbitration, so the RAM must answer it next cycle.
  a_ld_answered : assert property (@(posedge i_clk) disable iff (i_rst)
    o_bus.rd |=> o_ld_valid)
    else $error("load_store: load issued but no result returned.");

endmodule

// ==== lsu_subsystem.sv ====
// Data-memory subsystem joining the load/store unit and fetch port to a shared RAM.
`timescale 1ns/10ps

module lsu_subsystem #(
  parameter int unsigned MEM_WORDS = 256 // RAM depth in words.
) (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_lsu_stb,
  input  pkg_defines::lsu_req_t    i_lsu_req,
  input  logic                     i_fetch_stb,
  input  logic [pkg_mem::XLEN-1:0] i_fetch_addr,
  output logic                     o_ld_valid,
  output logic [pkg_mem::XLEN-1:0] o_ld_result,
  output logic                     o_misaligned,
  output logic                     o_fetch_valid,
  output logic [pkg_mem::XLEN-1:0] o_fetch_data
);
  import pkg_mem::*;

  mem_req_t lsu_bus;   // load/store unit to arbiter.
  mem_req_t fetch_bus; // fetch port to arbiter.
  mem_req_t ram_req;   // winner to RAM.
  mem_rsp_t ram_rsp;   // RAM answer, seen by both peers.
  logic     fetch_gnt; // fetch request taken this cycle.

  // ----------------------------------------------------------
  // requesters
  // ----------------------------------------------------------
  load_store lsu0 (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_stb        (i_lsu_stb),
    .i_req        (i_lsu_req),
    .i_rsp        (ram_rsp),
    .o_bus        (lsu_bus),
    .o_ld_valid   (o_ld_valid),
    .o_ld_result  (o_ld_result),
    .o_misaligned (o_misaligned)
  );

  fetch_port fetch0 (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_stb   (i_fetch_stb),
    .i_addr  (i_fetch_addr),
    .i_gnt   (fetch_gnt),
    .i_rsp   (ram_rsp),
    .o_bus   (fetch_bus),
    .o_valid (o_fetch_valid),
    .o_data  (o_fetch_data)
  );

  // ----------------------------------------------------------
  // shared memory
  // ----------------------------------------------------------
  mem_arbiter arb0 (
    .i_clk       (i_clk),
    .i_lsu_bus   (lsu_bus),
    .i_fetch_bus (fetch_bus),
    .o_ram_req   (ram_req),
    .o_fetch_gnt (fetch_gnt)
  );

  data_ram #(
    .MEM_WORDS (MEM_WORDS)
  ) ram0 (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_req (ram_req),
    .o_rsp (ram_rsp)
  );

endmodule

// ==== mem_arbiter.sv ====
// Fixed-priority RAM arbiter, load/store unit first and fetch port otherwise.
`timescale 1ns/10ps

module mem_arbiter (
  input  logic              i_clk,
  input  pkg_mem::mem_req_t i_lsu_bus,
  input  pkg_mem::mem_req_t i_fetch_bus,
  output pkg_mem::mem_req_t o_ram_req,
  output logic              o_fetch_gnt
);

  logic lsu_active;   // load/store unit asks this cycle.
  logic fetch_active; // fetch port asks this cycle.

  // ----------------------------------------------------------
  // priority select
  // ----------------------------------------------------------
  assign lsu_active   = i_lsu_bus.rd || i_lsu_bus.we;
  assign fetch_active = i_fetch_bus.rd || i_fetch_bus.we;

  // the load/store unit never waits. fetch takes the idle cycles.
  always_comb begin
    if (lsu_active) begin
      o_ram_req = i_lsu_bus;
    end else begin
      o_ram_req = i_fetch_bus; // idle fetch bus carries no strobes.
    end
  end

  assign o_fetch_gnt = fetch_active && !lsu_active;

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  a_gnt_excl : assert property (@(posedge i_clk)
    o_fetch_gnt |-> !(i_lsu_bus.rd || i_lsu_bus.we))
    else $error("mem_arbiter: fetch granted over a load/store request.");

  // the fetch side must hold its request while it is being refused.
  a_fetch_hold : assert property (@(posedge i_clk)
    (i_fetch_bus.rd && !o_fetch_gnt) |=> i_fetch_bus.rd)
    else $error("mem_arbiter: fetch request dropped before its grant.");

endmodule

// ==== pkg_defines.sv ====
// ISA definitions for the RV32 integer load and store instructions and the unit request.
package pkg_defines;

  // ----------------------------------------------------------
  // memory operation kinds
  // ----------------------------------------------------------
  typedef enum logic [3:0] {
    NONE, // no memory operation.
    LB,   // load byte, sign extended.
    LBU,  // load byte, zero extended.
    LH,   // load halfword, sign extended.
    LHU,  // load halfword, zero extended.
    LW,   // load word.
    SB,   // store byte.
    SH,   // store halfword.
    SW    // store word.
  } instr_name_e;

  // ----------------------------------------------------------
  // request presented to the load/store unit
  // ----------------------------------------------------------
  // the register fields are rv32 wide.
  typedef struct packed {
    instr_name_e instr;      // which load or store to perform.
    logic [31:0] base;       // data_1, the base register value.
    logic [31:0] store_data; // data_2, the value a store writes.
    logic [31:0] imm;        // sign-extended immediate offset.
  } lsu_req_t;

endpackage

// ==== pkg_mem.sv ====
// Memory bus definitions shared by the RAM, its arbiter and the two requesters.
package pkg_mem;

  // ----------------------------------------------------------
  // bus widths
  // ----------------------------------------------------------
  localparam int unsigned XLEN    = 32;       // data and byte address width.
  localparam int unsigned WADDR_W = XLEN - 2; // word address drops the byte offset.
  localparam int unsigned BE_W    = XLEN / 8; // one enable per byte lane.

  // ----------------------------------------------------------
  // request and response
  // ----------------------------------------------------------
  // a request is live in any cycle with rd or we set.
  typedef struct packed {
    logic               rd;    // read strobe.
    logic               we;    // write strobe.
    logic [WADDR_W-1:0] addr;  // word address.
    logic [XLEN-1:0]    wdata; // write data, already on its byte lanes.
    logic [BE_W-1:0]    be;    // byte enables for writes.
  } mem_req_t;

  // the response arrives one cycle after the read strobe.
  typedef struct packed {
    logic            valid; // read data is present this cycle.
    logic [XLEN-1:0] rdata; // the full addressed word.
  } mem_rsp_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_lsu \
  --Mdir obj_dir -o sim_lsu > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_lsu > sim.log 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status, see sim.log"
  exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi

// ==== tb_clock.sv ====
// Testbench clock and reset source, 100 ns period with reset held for the first 16 cycles.
`timescale 1ns/10ps

module tb_clock #(
  parameter int unsigned RST_CYCLES = 16 // rising edges seen with reset high.
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #50 o_clk = ~o_clk; // half of the 100 ns period.
  end

  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0; // released away from the sampling edge.
  end

endmodule

// ==== tb_lsu.sv ====
// Testbench driving random traffic into the data-memory subsystem against a byte shadow model.
`timescale 1ns/10ps

module tb_lsu;
  import pkg_defines::*;
  import pkg_mem::*;

  localparam int unsigned N1 = 32, N2 = 48, N3 = 16, N4 = 40, N5 = 240; // iterations per test.
  localparam int unsigned TOTAL_OPS = 17 + 256 + 2*N1 + 2*N2 + 13*N3 + 2*N4 + N5 + 4;
  localparam int unsigned TIMEOUT = 2*TOTAL_OPS + 200; // cycle budget for the whole run.

  typedef struct packed {
    logic [31:0] cyc;  // cycle in which the response is due.
    logic [31:0] data; // value the response must carry.
  } exp_t;

  logic clk, rst, i_lsu_stb, i_fetch_stb, o_ld_valid, o_misaligned, o_fetch_valid;
  lsu_req_t    i_lsu_req;
  logic [31:0] i_fetch_addr, o_ld_result, o_fetch_data;
  logic [7:0]  shadow [1024];            // byte image of the 256-word RAM.
  exp_t        ld_exp[$], fe_exp[$];     // due load and fetch results.
  logic [31:0] mis_exp[$];               // cycles in which o_misaligned must pulse.
  int unsigned now = 0, cycles = 0;      // stimulus cycle and free-running cycle count.
  logic        fetch_pend = 1'b0;        // the model has a fetch not yet granted.
  logic [31:0] fetch_addr = '0;          // byte address of that fetch.
  string       test_name = "reset";

  tb_clock clk0 (.o_clk(clk), .o_rst(rst));

  lsu_subsystem dut0 (
    .i_clk(clk), .i_rst(rst), .i_lsu_stb(i_lsu_stb), .i_lsu_req(i_lsu_req),
    .i_fetch_stb(i_fetch_stb), .i_fetch_addr(i_fetch_addr), .o_ld_valid(o_ld_valid),
    .o_ld_result(o_ld_result), .o_misaligned(o_misaligned), .o_fetch_valid(o_fetch_valid),
    .o_fetch_data(o_fetch_data)
  );

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  function automatic logic [31:0] word_at(logic [31:0] a);
    return {shadow[{a[9:2], 2'd3}], shadow[{a[9:2], 2'd2}],
            shadow[{a[9:2], 2'd1}], shadow[{a[9:2], 2'd0}]}; // little-endian lanes.
  endfunction

  function automatic logic [31:0] load_value(instr_name_e k, logic [31:0] a);
    logic [7:0] b0, b1;
    b0 = shadow[a[9:0]];
    b1 = shadow[a[9:0] + 10'd1]; // halfwords are even, so this stays in the word.
    case (k)
      LB:      return {{24{b0[7]}}, b0};
      LBU:     return {24'd0, b0};
      LH:      return {{16{b1[7]}}, b1, b0};
      LHU:     return {16'd0, b1, b0};
      default: return word_at(a);
    endcase
  endfunction

  function automatic logic misaligned_for(instr_name_e k, logic [31:0] a);
    if (k inside {LH, LHU, SH}) return a[0];      // halfwords need an even address.
    if (k inside {LW, SW}) return |a[1:0];        // words need a multiple of four.
    return 1'b0;
  endfunction

  task automatic write_shadow(instr_name_e k, logic [31:0] a, logic [31:0] d);
    int unsigned n;
    n = (k == SB) ? 1 : (k == SH) ? 2 : 4; // bytes written by the store.
    for (int j = 0; j < n; j++) shadow[a[9:0] + 10'(j)] = d[8*j +: 8];
  endtask

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] aligned_addr(instr_name_e k);
    logic [31:0] a;
    a = $urandom;
    if (k inside {LH, LHU, SH}) a[0] = 1'b0;
    if (k inside {LW, SW}) a[1:0] = 2'b00;
    return a;
  endfunction

  // the address is split into a random 12-bit immediate and the base that completes it.
  function automatic lsu_req_t make_req(instr_name_e k, logic [31:0] a, logic [31:0] d);
    lsu_req_t r;
    logic [11:0] imm12;
    imm12 = 12'($urandom);
    r.instr      = k;
    r.imm        = {{20{imm12[11]}}, imm12};
    r.base       = a - r.imm;
    r.store_data = d;
    return r;
  endfunction

  task automatic value_error(string sig, logic [31:0] exp_v, logic [31:0] act_v);
    $display("ERR %s %s expected %h actual %h", test_name, sig, exp_v, act_v);
    $display("TEST FAILED");
    $fatal(1, "output mismatch");
  endtask

  // outputs are registered, so the falling edge sees them settled.
  task automatic check_outputs();
    logic exp_ld, exp_mis, exp_fe;
    exp_ld  = ld_exp.size() > 0 && ld_exp[0].cyc == now;
    exp_mis = mis_exp.size() > 0 && mis_exp[0] == now;
    exp_fe  = fe_exp.size() > 0 && fe_exp[0].cyc == now;
    assert (o_ld_valid === exp_ld) else value_error("o_ld_valid", 32'(exp_ld), 32'(o_ld_valid));
    assert (o_misaligned === exp_mis)
      else value_error("o_misaligned", 32'(exp_mis), 32'(o_misaligned));
    assert (o_fetch_valid === exp_fe)
      else value_error("o_fetch_valid", 32'(exp_fe), 32'(o_fetch_valid));
    if (exp_ld) begin
      assert (o_ld_result === ld_exp[0].data)
        else value_error("o_ld_result", ld_exp[0].data, o_ld_result);
      void'(ld_exp.pop_front());
    end
    if (exp_mis) void'(mis_exp.pop_front());
    if (exp_fe) begin
      assert (o_fetch_data === fe_exp[0].data)
        else value_error("o_fetch_data", fe_exp[0].data, o_fetch_data);
      void'(fe_exp.pop_front());
    end
  endtask

  // one cycle whose requests reset must swallow without a trace.
  task automatic drive_in_reset(logic stb, lsu_req_t req, logic fstb, logic [31:0] faddr);
    @(negedge clk);
    check_outputs();
    i_lsu_stb    = stb;
    i_lsu_req    = req;
    i_fetch_stb  = fstb;
    i_fetch_addr = faddr;
    now++;
  endtask

  // one cycle checks last cycle's results, drives new inputs and advances the model.
  task automatic step(logic stb, lsu_req_t req, logic fstb, logic [31:0] faddr);
    logic [31:0] a;
    logic        bad, active;
    exp_t        e;
    @(negedge clk);
    check_outputs();
    i_lsu_stb    = stb;
    i_lsu_req    = req;
    i_fetch_stb  = fstb;
    i_fetch_addr = faddr;
    a      = req.base + req.imm;
    bad    = stb && misaligned_for(req.instr, a);
    active = stb && !bad && req.instr != NONE; // only these reach the RAM.
    e.cyc  = now + 1;
    if (bad) mis_exp.push_back(now + 1);
    if (active && req.instr inside {LB, LBU, LH, LHU, LW}) begin
      e.data = load_value(req.instr, a);
      ld_exp.push_back(e);
    end
    if (active && req.instr inside {SB, SH, SW}) write_shadow(req.instr, a, req.store_data);
    if (fstb) begin
      fetch_pend = 1'b1;
      fetch_addr = faddr;
    end
    if (fetch_pend && !active) begin // fetch takes the first cycle left free.
      e.data = word_at(fetch_addr);
      fe_exp.push_back(e);
      fetch_pend = 1'b0;
    end
    now++;
  endtask

  task automatic issue(instr_name_e k, logic [31:0] a, logic [31:0] d);
    step(1'b1, make_req(k, a, d), 1'b0, '0);
  endtask

  // ----------------------------------------------------------
  // run control
  // ----------------------------------------------------------
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    logic [31:0] a;
    instr_name_e k;
    int unsigned r;
    logic        fstb;
    i_lsu_stb    = 1'b0;
    i_lsu_req    = '0;
    i_fetch_stb  = 1'b0;
    i_fetch_addr = '0;
    void'($urandom(32'h82ff_91c9));
    for (int i = 0; i < 1024; i++) shadow[i] = 8'h00;

    // loads and fetches alternate while reset is sampled high and the last two cycles idle.
    for (int c = 0; c < 17; c++) begin // reset cycles plus the first one after.
      k = instr_name_e'($urandom_range(1, 5));
      if (c >= 15) begin
        drive_in_reset(1'b0, '0, 1'b0, '0); // these inputs are sampled after reset.
      end else if (c % 2 == 0) begin
        drive_in_reset(1'b1, make_req(k, $urandom, $urandom), 1'b0, '0);
      end else begin
        drive_in_reset(1'b0, '0, 1'b1, $urandom);
      end
    end

    test_name = "clear";
    for (int w = 0; w < 256; w++) issue(SW, {22'($urandom), 8'(w), 2'b00}, '0);

    test_name = "word_store_load";
    for (int n = 0; n < N1; n++) begin
      a = aligned_addr(SW);
      issue(SW, a, $urandom);
      issue(LW, a, '0);
    end

    test_name = "byte_half_merge";
    for (int n = 0; n < N2; n++) begin
      k = $urandom_range(0, 1) ? SB : SH;
      a = aligned_addr(k);
      a[9:5] = 5'd3; // eight words let the stores pile up on each other.
      issue(k, a, $urandom);
      issue(LW, a & ~32'd3, '0);
    end

    test_name = "load_extension";
    for (int n = 0; n < N3; n++) begin
      a = aligned_addr(SW);
      issue(SW, a, $urandom);
      for (int l = 0; l < 4; l++) begin
        issue(LB, a + 32'(l), '0);
        issue(LBU, a + 32'(l), '0);
        if (l % 2 == 0) begin
          issue(LH, a + 32'(l), '0);
          issue(LHU, a + 32'(l), '0);
        end
      end
    end

    test_name = "misaligned";
    for (int n = 0; n < N4; n++) begin
      r = $urandom_range(0, 4);
      k = (r == 0) ? LH : (r == 1) ? LHU : (r == 2) ? SH : (r == 3) ? LW : SW;
      a = $urandom;
      if (k inside {LH, LHU, SH}) a[0] = 1'b1;
      else a[1:0] = 2'($urandom_range(1, 3));
      issue(k, a, $urandom);
      issue(LW, a & ~32'd3, '0); // the word must still hold its old value.
    end

    test_name = "fetch_contention";
    for (int n = 0; n < N5; n++) begin
      r = $urandom_range(0, 2); // idle, load or store.
      k = (r == 1) ? instr_name_e'($urandom_range(1, 5)) : instr_name_e'($urandom_range(6, 8));
      fstb = !fetch_pend && 1'($urandom_range(0, 1));
      step(r != 0, make_req(k, aligned_addr(k), $urandom), fstb, $urandom);
    end
    repeat (4) step(1'b0, '0, 1'b0, '0); // lets the last fetch drain.

    if (ld_exp.size() == 0 && fe_exp.size() == 0 && mis_exp.size() == 0 && !fetch_pend) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("expected responses were still outstanding at the end of the run");
      $display("TEST FAILED");
      $fatal(1, "responses missing");
    end
  end

endmodule

// ==== vlog.f ====
pkg_defines.sv
pkg_mem.sv
load_store.sv
fetch_port.sv
mem_arbiter.sv
data_ram.sv
lsu_subsystem.sv
tb_clock.sv
tb_lsu.sv
